/* hdl/buf_rd_pkg.sv */
`default_nettype none

package buf_rd_pkg;

	// word index width inside one segment, 2**SEG_W words per segment
	localparam int SEG_W = 2;
	// segment address width
	localparam int SEG_AW = 4;
	// flow id width, 2**FLOWS_W flows
	localparam int FLOWS_W = 2;
	localparam int NUM_FLOWS = 1 << FLOWS_W;
	// last flag + last word index + segment address
	localparam int PTR_W = SEG_AW + SEG_W + 1;

	typedef logic [SEG_AW-1:0] seg_addr_t;
	typedef logic [SEG_W-1:0] word_idx_t;
	typedef logic [FLOWS_W-1:0] flow_id_t;
	typedef logic [PTR_W-1:0] ptr_entry_t;
	// segment address on top, word index below
	typedef logic [SEG_AW+SEG_W-1:0] buf_addr_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_fetch,
		seq_stream,
		seq_wait
	} seq_state_t;

	// field accessors for a pointer entry
	function automatic logic ptr_last(ptr_entry_t e);
		return e[PTR_W-1];
	endfunction

	// only meaningful on the last segment of a packet
	function automatic word_idx_t ptr_idx(ptr_entry_t e);
		return e[SEG_AW+SEG_W-1:SEG_AW];
	endfunction

	function automatic seg_addr_t ptr_seg(ptr_entry_t e);
		return e[SEG_AW-1:0];
	endfunction

endpackage

`default_nettype wire

/* hdl/flow_ptr_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_ptr_fifo
	import buf_rd_pkg::*;
#(
	parameter int FIFO_AW = 3
) (
	input  wire logic       clk,
	input  wire logic       rstn,
	input  wire logic       push,
	input  wire ptr_entry_t push_entry,
	input  wire logic       pop,
	output ptr_entry_t      head,
	output logic            empty
);

	localparam int DEPTH = 1 << FIFO_AW;

	// pointer storage
	ptr_entry_t mem [DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	// one extra bit so a full queue is distinct from empty
	logic [FIFO_AW:0] count;

	assign empty = (count == '0);

	// control state
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop keeps the count
			if (push && !pop)
				count <= count + 1'b1;
			else if (!push && pop)
				count <= count - 1'b1;
		end
	end

	// storage write and registered head
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_entry;
		// head shows the popped entry one cycle later
		if (pop)
			head <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

/* hdl/flow_rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_rr_arbiter
	import buf_rd_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 rstn,
	input  wire logic [NUM_FLOWS-1:0] nonempty,
	input  wire logic                 grant_take,
	output flow_id_t                  grant_flow,
	output logic                      grant_valid
);

	// search start point, moves past each flow that is served
	flow_id_t rr_ptr;

	// scan state for the combinational search
	flow_id_t cand;
	logic found;

	// any queued pointer means a grant is available
	assign grant_valid = |nonempty;

	// first non-empty flow at or after rr_ptr, wrapping around
	always_comb begin
		grant_flow = rr_ptr;
		found = 1'b0;
		cand = rr_ptr;
		for (int i = 0; i < NUM_FLOWS; i++) begin
			// flow id arithmetic wraps on its own width
			cand = rr_ptr + flow_id_t'(i);
			if (!found && nonempty[cand]) begin
				grant_flow = cand;
				found = 1'b1;
			end
		end
	end

	// pointer update
	// only when the sequencer actually pops the granted flow
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rr_ptr <= '0;
		end else if (grant_take) begin
			// next search starts just after the flow taken
			rr_ptr <= grant_flow + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/seg_read_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_read_seq
	import buf_rd_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 rstn,
	input  wire logic [NUM_FLOWS-1:0] nonempty,
	input  wire ptr_entry_t           heads [NUM_FLOWS],
	input  wire flow_id_t             grant_flow,
	input  wire logic                 grant_valid,
	output logic                      grant_take,
	output logic [NUM_FLOWS-1:0]      pop,
	output buf_addr_t                 b_raddr,
	output logic                      s_rvalid
);

	seq_state_t state;
	seq_state_t state_nxt;

	// flow being streamed, held for the whole packet
	flow_id_t cur_flow;
	// segment pointer being walked
	ptr_entry_t cur_entry;
	// word position inside the segment
	word_idx_t word_cnt;

	// final word of the final segment
	logic pkt_end;
	// final word of a segment with more to follow
	logic seg_wrap;
	// next segment of the current packet already queued
	logic flow_ready;

	assign pkt_end = ptr_last(cur_entry) && (word_cnt == ptr_idx(cur_entry));
	assign seg_wrap = !ptr_last(cur_entry) && (word_cnt == {SEG_W{1'b1}});
	assign flow_ready = nonempty[cur_flow];

	// read address straight from the walk registers
	assign b_raddr = {ptr_seg(cur_entry), word_cnt};

	// next state, pop strobes and grant acknowledge
	always_comb begin
		state_nxt = state;
		pop = '0;
		grant_take = 1'b0;
		case (state)
			seq_idle: begin
				// new flow only at a packet boundary
				if (grant_valid) begin
					grant_take = 1'b1;
					pop[grant_flow] = 1'b1;
					state_nxt = seq_fetch;
				end
			end
			seq_fetch: begin
				// head of the popped queue is visible now
				state_nxt = seq_stream;
			end
			seq_stream: begin
				if (pkt_end) begin
					state_nxt = seq_idle;
				end else if (seg_wrap) begin
					// stay on the same flow for the next segment
					if (flow_ready) begin
						pop[cur_flow] = 1'b1;
						state_nxt = seq_fetch;
					end else begin
						state_nxt = seq_wait;
					end
				end
			end
			seq_wait: begin
				// writer has not queued the next segment yet
				// no other flow may cut in here
				if (flow_ready) begin
					pop[cur_flow] = 1'b1;
					state_nxt = seq_fetch;
				end
			end
			default: begin
				state_nxt = seq_idle;
			end
		endcase
	end

	// control registers
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= seq_idle;
			cur_flow <= '0;
			word_cnt <= '0;
			s_rvalid <= 1'b0;
		end else begin
			state <= state_nxt;
			if (grant_take)
				cur_flow <= grant_flow;
			// every segment walk starts at word 0
			if (state == seq_fetch)
				word_cnt <= '0;
			else if (state == seq_stream && !pkt_end && !seg_wrap)
				word_cnt <= word_cnt + 1'b1;
			// read data strobe, one cycle behind the address
			s_rvalid <= (state == seq_stream);
		end
	end

	// capture the new segment pointer
	always_ff @(posedge clk) begin
		if (state == seq_fetch)
			cur_entry <= heads[cur_flow];
	end

endmodule

`default_nettype wire

/* hdl/buf_rd_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module buf_rd_sched
	import buf_rd_pkg::*;
#(
	// log2 of the per-flow queue depth
	parameter int FIFO_AW = 3
) (
	input  wire logic       clk,
	input  wire logic       rstn,
	input  wire ptr_entry_t used_pointer,
	input  wire logic       used_pointer_valid,
	input  wire flow_id_t   used_pointer_flow,
	output buf_addr_t       b_raddr,
	output logic            s_rvalid
);

	// per-queue push strobes decoded from the flow id
	logic [NUM_FLOWS-1:0] push_vec;
	// one-hot pops from the sequencer
	logic [NUM_FLOWS-1:0] pop_vec;
	logic [NUM_FLOWS-1:0] empty_vec;
	logic [NUM_FLOWS-1:0] nonempty;
	ptr_entry_t heads [NUM_FLOWS];

	// arbiter to sequencer
	flow_id_t grant_flow;
	logic grant_valid;
	logic grant_take;

	assign nonempty = ~empty_vec;

	// one pointer queue per flow
	for (genvar g = 0; g < NUM_FLOWS; g++) begin : gen_flow_q
		assign push_vec[g] = used_pointer_valid && (used_pointer_flow == flow_id_t'(g));

		flow_ptr_fifo #(
			.FIFO_AW(FIFO_AW)
		) u_fifo (
			.clk(clk),
			.rstn(rstn),
			.push(push_vec[g]),
			.push_entry(used_pointer),
			.pop(pop_vec[g]),
			.head(heads[g]),
			.empty(empty_vec[g])
		);
	end

	// picks the next flow for the sequencer
	flow_rr_arbiter u_arb (
		.clk(clk),
		.rstn(rstn),
		.nonempty(nonempty),
		.grant_take(grant_take),
		.grant_flow(grant_flow),
		.grant_valid(grant_valid)
	);

	// shared read address generator
	seg_read_seq u_seq (
		.clk(clk),
		.rstn(rstn),
		.nonempty(nonempty),
		.heads(heads),
		.grant_flow(grant_flow),
		.grant_valid(grant_valid),
		.grant_take(grant_take),
		.pop(pop_vec),
		.b_raddr(b_raddr),
		.s_rvalid(s_rvalid)
	);

endmodule

`default_nettype wire

/* tb/buf_rd_sched_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module buf_rd_sched_assertions
	import buf_rd_pkg::*;
(
	input wire logic                 clk,
	input wire logic                 rstn,
	input wire logic [NUM_FLOWS-1:0] pop_vec,
	input wire logic [NUM_FLOWS-1:0] nonempty,
	input wire logic                 s_rvalid
);

	// one queue popped at most
	a_pop_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(pop_vec))
		else $error("more than one pointer queue popped in a cycle");

	// never pop a drained queue
	a_pop_nonempty: assert property (@(posedge clk) disable iff (!rstn) (pop_vec & ~nonempty) == '0)
		else $error("pop issued to an empty pointer queue");

	// fetch cycle always separates two pops
	a_pop_spacing: assert property (@(posedge clk) disable iff (!rstn) |pop_vec |=> !(|pop_vec))
		else $error("pops in two consecutive cycles");

	// read strobe quiet while in reset
	a_rvalid_reset: assert property (@(posedge clk) !rstn |=> !s_rvalid)
		else $error("s_rvalid high during reset");

endmodule

bind buf_rd_sched buf_rd_sched_assertions u_assertions (
	.clk(clk),
	.rstn(rstn),
	.pop_vec(pop_vec),
	.nonempty(nonempty),
	.s_rvalid(s_rvalid)
);

`default_nettype wire

/* tb/tb_buf_rd_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_buf_rd_sched
	import buf_rd_pkg::*;
();

	localparam int WORDS = 1 << SEG_W;
	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 10;
	// whole run stays far below this even with slow random pushes
	localparam int WATCHDOG_CYCLES = 20000;
	// longest quiet stretch allowed while words are still owed
	localparam int DRAIN_CYCLES = 2000;
	// random writer keeps each flow below the fifo depth of 8
	localparam int MAX_QUEUED = 6;

	// one expected read word
	typedef struct packed {
		logic pkt_end;
		logic seg_end;
		buf_addr_t addr;
	} exp_word_t;

	logic clk;
	logic rstn;
	ptr_entry_t used_pointer;
	logic used_pointer_valid;
	flow_id_t used_pointer_flow;
	buf_addr_t b_raddr;
	logic s_rvalid;

	// expected words per flow in read order
	exp_word_t exp_q [NUM_FLOWS][$];
	// segments pushed but not yet seen in full on the output
	int seg_pending [NUM_FLOWS];
	// low bits of the next segment address per flow
	logic [SEG_AW-FLOWS_W-1:0] seg_seq [NUM_FLOWS];
	// flows in the order their packets started on the output
	flow_id_t pkt_log [$];
	buf_addr_t prev_raddr;
	int beats;
	logic in_pkt;
	flow_id_t pkt_flow;
	logic verdict_done;
	int seed;

	buf_rd_sched #(
		.FIFO_AW(3)
	) dut (
		.clk(clk),
		.rstn(rstn),
		.used_pointer(used_pointer),
		.used_pointer_valid(used_pointer_valid),
		.used_pointer_flow(used_pointer_flow),
		.b_raddr(b_raddr),
		.s_rvalid(s_rvalid)
	);

	always #(CLK_HALF) clk = ~clk;

	task automatic stop_with_failure();
		verdict_done = 1'b1;
		$display("tests failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string what);
		$display("FAILED at %0t: %s", $time, what);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("error at %0t: %s", $time, what);
		stop_with_failure();
	endtask

	function automatic int words_left();
		int n;
		n = 0;
		for (int i = 0; i < NUM_FLOWS; i++)
			n += exp_q[i].size();
		return n;
	endfunction

	// after flow last the search restarts at last+1 and wraps
	function automatic flow_id_t rr_next(input flow_id_t last,
		input logic [NUM_FLOWS-1:0] waiting);
		flow_id_t pick;
		flow_id_t f;
		logic found;
		pick = last;
		found = 1'b0;
		for (int i = 1; i <= NUM_FLOWS; i++) begin
			f = last + flow_id_t'(i);
			if (!found && waiting[f]) begin
				pick = f;
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	// flow id rides in the top bits of every segment address
	function automatic seg_addr_t next_seg(input flow_id_t f);
		seg_addr_t s;
		s = {f, seg_seq[f]};
		seg_seq[f] = seg_seq[f] + 1'b1;
		return s;
	endfunction

	// one output beat against the owning flow's model queue
	task automatic check_beat(input buf_addr_t addr);
		flow_id_t f;
		exp_word_t e;
		f = addr[SEG_AW+SEG_W-1 -: FLOWS_W];
		beats++;
		if (in_pkt) begin
			assert (f == pkt_flow)
			else report_mismatch($sformatf("flow %0d cut into a packet of flow %0d",
				f, pkt_flow));
		end
		assert (exp_q[f].size() > 0)
		else report_problem($sformatf("address 0x%0h read with nothing queued on flow %0d",
			addr, f));
		e = exp_q[f].pop_front();
		assert (e.addr == addr)
		else report_mismatch($sformatf("flow %0d expected 0x%0h, got 0x%0h", f, e.addr, addr));
		if (!in_pkt)
			pkt_log.push_back(f);
		if (e.seg_end)
			seg_pending[f]--;
		in_pkt = !e.pkt_end;
		pkt_flow = f;
	endtask

	// s_rvalid marks the address of the cycle before
	always @(posedge clk) begin
		if (s_rvalid)
			check_beat(prev_raddr);
		prev_raddr <= b_raddr;
	end

	// model gets the words of the segment before the push strobe goes out
	task automatic push_segment(input flow_id_t f, input logic last, input word_idx_t idx,
		input seg_addr_t seg);
		int n_words;
		exp_word_t w;
		// a non-last segment is read in full whatever its index field
		n_words = last ? int'(idx) + 1 : WORDS;
		for (int i = 0; i < n_words; i++) begin
			w.addr = {seg, word_idx_t'(i)};
			w.seg_end = (i == n_words - 1);
			w.pkt_end = last && (i == n_words - 1);
			exp_q[f].push_back(w);
		end
		seg_pending[f]++;
		@(posedge clk);
		used_pointer <= {last, idx, seg};
		used_pointer_flow <= f;
		used_pointer_valid <= 1'b1;
	endtask

	task automatic release_bus();
		@(posedge clk);
		used_pointer_valid <= 1'b0;
	endtask

	// segments back to back with idx used only on the last one
	task automatic push_packet(input flow_id_t f, input int nseg, input word_idx_t idx);
		for (int s = 0; s < nseg; s++)
			push_segment(f, s == nseg - 1, (s == nseg - 1) ? idx : ~idx, next_seg(f));
		release_bus();
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (words_left() != 0) begin
			@(posedge clk);
			waited++;
			assert (waited <= DRAIN_CYCLES)
			else report_problem("read stream stalled with words still expected");
		end
		// a stray extra beat would hit the monitor in this quiet stretch
		repeat (8) @(posedge clk);
	endtask

	task automatic check_beats(input int start, input int n);
		assert (beats - start == n)
		else report_mismatch($sformatf("%0d beats seen, %0d expected", beats - start, n));
	endtask

	task automatic check_order(input flow_id_t want [$]);
		assert (pkt_log.size() == want.size())
		else report_mismatch($sformatf("%0d packets seen, %0d expected",
			pkt_log.size(), want.size()));
		foreach (want[i]) begin
			assert (pkt_log[i] == want[i])
			else report_mismatch($sformatf("packet %0d from flow %0d, expected flow %0d",
				i, pkt_log[i], want[i]));
		end
	endtask

	task automatic single_segment_packet();
		int start;
		start = beats;
		push_packet(flow_id_t'(1), 1, word_idx_t'(2));
		wait_drained();
		check_beats(start, 3);
	endtask

	// two full segments and a one-word tail
	task automatic multi_segment_packet();
		int start;
		start = beats;
		push_packet(flow_id_t'(3), 3, word_idx_t'(0));
		wait_drained();
		check_beats(start, 9);
	endtask

	task automatic rr_at_packet_boundaries();
		flow_id_t want [$];
		logic [NUM_FLOWS-1:0] waiting;
		flow_id_t last;
		pkt_log.delete();
		push_packet(flow_id_t'(0), 3, word_idx_t'(3));
		// these land while flow 0 is still mid packet
		push_packet(flow_id_t'(3), 1, word_idx_t'(1));
		push_packet(flow_id_t'(1), 1, word_idx_t'(0));
		push_packet(flow_id_t'(2), 1, word_idx_t'(2));
		want.push_back(flow_id_t'(0));
		waiting = 4'b1110;
		last = flow_id_t'(0);
		for (int i = 0; i < 3; i++) begin
			last = rr_next(last, waiting);
			want.push_back(last);
			waiting[last] = 1'b0;
		end
		wait_drained();
		check_order(want);
	endtask

	task automatic mid_packet_starvation();
		flow_id_t want [$];
		int start;
		start = beats;
		pkt_log.delete();
		// head segment of flow 2 while its tail is held back
		push_segment(flow_id_t'(2), 1'b0, word_idx_t'(0), next_seg(flow_id_t'(2)));
		push_packet(flow_id_t'(0), 1, word_idx_t'(3));
		repeat (20) @(posedge clk);
		// flow 2 stalls after one segment and flow 0 stays out
		check_beats(start, WORDS);
		push_segment(flow_id_t'(2), 1'b1, word_idx_t'(1), next_seg(flow_id_t'(2)));
		release_bus();
		wait_drained();
		check_beats(start, WORDS + 2 + 4);
		want.push_back(flow_id_t'(2));
		want.push_back(flow_id_t'(0));
		check_order(want);
	endtask

	task automatic random_traffic();
		flow_id_t f;
		int nseg;
		word_idx_t idx;
		for (int p = 0; p < 40; p++) begin
			f = flow_id_t'($unsigned($random(seed)) % NUM_FLOWS);
			nseg = 1 + int'($unsigned($random(seed)) % 3);
			idx = word_idx_t'($unsigned($random(seed)));
			// hold off until the flow has room for the whole packet
			while (seg_pending[f] + nseg > MAX_QUEUED)
				@(posedge clk);
			push_packet(f, nseg, idx);
			repeat (int'($unsigned($random(seed)) % 4)) @(posedge clk);
		end
		wait_drained();
	endtask

	initial begin
		clk = 1'b0;
		rstn <= 1'b0;
		used_pointer <= '0;
		used_pointer_valid <= 1'b0;
		used_pointer_flow <= '0;
		seed = 32'h4c564da7;
		beats = 0;
		in_pkt = 1'b0;
		pkt_flow = '0;
		verdict_done = 1'b0;
		for (int i = 0; i < NUM_FLOWS; i++) begin
			seg_pending[i] = 0;
			seg_seq[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b1;
		repeat (2) @(posedge clk);
		single_segment_packet();
		multi_segment_packet();
		rr_at_packet_boundaries();
		mid_packet_starvation();
		random_traffic();
		verdict_done = 1'b1;
		$display("all tests passed");
		$finish;
	end

	// hang guard
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_problem("watchdog expired, the run hung");
	end

	// run ended before the verdict
	final begin
		if (!verdict_done)
			$display("tests failed");
	end

endmodule

`default_nettype wire

/* tb.f */
hdl/buf_rd_pkg.sv
hdl/flow_ptr_fifo.sv
hdl/flow_rr_arbiter.sv
hdl/seg_read_seq.sv
hdl/buf_rd_sched.sv
tb/buf_rd_sched_assertions.sv
tb/tb_buf_rd_sched.sv

/* Makefile */
TOP := tb_buf_rd_sched

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the verdict"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -j 0 -f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
